// ==== compile.f ====
+incdir+hdl
hdl/cluster_periph_pkg.sv
hdl/periph_apb_demux.sv
hdl/cluster_ctrl_unit.sv
hdl/cluster_timer.sv
hdl/event_unit.sv
hdl/cluster_periph_top.sv
dv/cluster_periph_checker.sv
dv/cluster_periph_tb.sv

// ==== Makefile ====
# Verilator build and run for the cluster peripheral testbench

VERILATOR ?= verilator
TOP       ?= cluster_periph_tb
BUILD_DIR ?= obj_dir
FILELIST  ?= compile.f
VFLAGS    ?= --binary --timing --assert -Wno-fatal

SIM_BIN := $(BUILD_DIR)/V$(TOP)
SOURCES := $(filter-out +%,$(shell cat $(FILELIST)))
HEADERS := $(wildcard hdl/*.svh)

.PHONY: all build run clean

all: run

build: $(SIM_BIN)

# rebuilt only when a source, a header or the file list changes
$(SIM_BIN): $(FILELIST) $(SOURCES) $(HEADERS)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	./$(SIM_BIN)

clean:
	rm -rf $(BUILD_DIR)

// ==== dv/cluster_periph_tb.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "cluster_periph_defs.svh"

module cluster_periph_tb
  import cluster_periph_pkg::*;
();

  localparam int TMR_CMP       = 20;
  localparam int CYC_PER_ENTRY = 4;

  typedef struct packed {
    logic      wr;
    addr_t     addr;
    data_t     wdata;
    ext_evt_t  ext;
    data_t     rdata;
    logic      err;
    core_vec_t irq;
  } entry_t;

  logic        clk;
  logic        arst_n;
  apb_req_t    apb_req;
  apb_rsp_t    apb_rsp;
  ext_evt_t    ext_evt;
  logic        eoc;
  core_vec_t   fetch_en;
  boot_addr_t  boot_addr;
  core_vec_t   irq_req;

  entry_t      table_q[$];
  string       name_q[$];
  data_t       boot_val [`CP_NB_CORES];
  int          seed;
  int          errors;
  int unsigned cycles = 0;
  int unsigned cycle_limit = 0;

  cluster_periph_top uut (
    .clk_i       ( clk       ),
    .arst_n_i    ( arst_n    ),
    .apb_req_i   ( apb_req   ),
    .apb_rsp_o   ( apb_rsp   ),
    .ext_evt_i   ( ext_evt   ),
    .eoc_o       ( eoc       ),
    .fetch_en_o  ( fetch_en  ),
    .boot_addr_o ( boot_addr ),
    .irq_req_o   ( irq_req   )
  );

  always #2 clk = ~clk;

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycle_limit != 0 && cycles > cycle_limit) begin
      $display("Errors found");
      $fatal(1, "timeout, run still busy after %0d cycles", cycles);
    end
  end

  // ******************************
  // checks
  // ******************************
  task automatic fail_now(input string what);
    errors++;
    $display("%s", what);
    $display("Errors found");
    $fatal(1, "stopped at first failing check");
  endtask

  task automatic check_data(input string name, input data_t exp, input data_t act);
    if (act !== exp) fail_now($sformatf("[ERROR] %s: expected 0x%08h, actual 0x%08h",
                                        name, exp, act));
  endtask

  task automatic check_vec(input string name, input core_vec_t exp, input core_vec_t act);
    if (act !== exp) fail_now($sformatf("[ERROR] %s: expected %b, actual %b", name, exp, act));
  endtask

  task automatic check_bit(input string name, input logic exp, input logic act);
    if (act !== exp) fail_now($sformatf("[ERROR] %s: expected %b, actual %b", name, exp, act));
  endtask

  // ******************************
  // stimulus table
  // ******************************
  function automatic addr_t reg_addr(input periph_sel_e sel, input int offs);
    return {sel, offs_t'(offs)};
  endfunction

  task automatic add_read(input string name, input addr_t addr, input ext_evt_t ext,
                          input data_t rdata, input logic err, input core_vec_t irq);
    table_q.push_back({1'b0, addr, data_t'(0), ext, rdata, err, irq});
    name_q.push_back(name);
  endtask

  task automatic add_write(input string name, input addr_t addr, input data_t wdata,
                           input logic err, input core_vec_t irq);
    table_q.push_back({1'b1, addr, wdata, ext_evt_t'(0), data_t'(0), err, irq});
    name_q.push_back(name);
  endtask

  task automatic build_table();
    for (int i = 0; i < `CP_NB_CORES; i++) begin
      boot_val[i] = $random(seed);
    end
    // reset values
    add_read("rst_eoc", reg_addr(SEL_CTRL, CTRL_EOC), '0, '0, 1'b0, '0);
    add_read("rst_fetch_en", reg_addr(SEL_CTRL, CTRL_FETCH_EN), '0, '0, 1'b0, '0);
    for (int i = 0; i < `CP_NB_CORES; i++) begin
      add_read($sformatf("rst_boot%0d", i), reg_addr(SEL_CTRL, CTRL_BOOT_ADDR + 4 * i), '0,
               `CP_BOOT_ADDR_RST, 1'b0, '0);
    end
    add_read("rst_tmr_cmp", reg_addr(SEL_TIMER, TIMER_CMP), '0, '1, 1'b0, '0);
    add_read("rst_tmr_cfg", reg_addr(SEL_TIMER, TIMER_CFG), '0, '0, 1'b0, '0);
    // control registers
    for (int i = 0; i < `CP_NB_CORES; i++) begin
      add_write($sformatf("boot_wr%0d", i), reg_addr(SEL_CTRL, CTRL_BOOT_ADDR + 4 * i),
                boot_val[i], 1'b0, '0);
    end
    add_write("fetch_en_wr", reg_addr(SEL_CTRL, CTRL_FETCH_EN), 32'h5, 1'b0, '0);
    add_write("eoc_wr", reg_addr(SEL_CTRL, CTRL_EOC), 32'h1, 1'b0, '0);
    for (int i = 0; i < `CP_NB_CORES; i++) begin
      add_read($sformatf("boot_rd%0d", i), reg_addr(SEL_CTRL, CTRL_BOOT_ADDR + 4 * i), '0,
               boot_val[i], 1'b0, '0);
    end
    add_read("fetch_en_rd", reg_addr(SEL_CTRL, CTRL_FETCH_EN), '0, 32'h5, 1'b0, '0);
    add_read("eoc_rd", reg_addr(SEL_CTRL, CTRL_EOC), '0, 32'h1, 1'b0, '0);
    // decode errors, then the same registers again
    add_read("region3_rd", reg_addr(SEL_NONE, 'h0), '0, '0, 1'b1, '0);
    add_write("region3_wr", reg_addr(SEL_NONE, 'h4), 32'hff, 1'b1, '0);
    add_write("ctrl_unknown_wr", reg_addr(SEL_CTRL, 'h10), 32'hfe, 1'b1, '0);
    add_read("ctrl_unknown_rd", reg_addr(SEL_CTRL, 'h04), '0, '0, 1'b1, '0);
    add_write("eu_buf_wr", reg_addr(SEL_EU, EU_BUFFER), 32'hffff, 1'b1, '0);
    add_read("boot_rd0_after_err", reg_addr(SEL_CTRL, CTRL_BOOT_ADDR), '0, boot_val[0],
             1'b0, '0);
    add_read("fetch_en_after_err", reg_addr(SEL_CTRL, CTRL_FETCH_EN), '0, 32'h5, 1'b0, '0);
    add_read("eoc_after_err", reg_addr(SEL_CTRL, CTRL_EOC), '0, 32'h1, 1'b0, '0);
    add_read("eu_buf0_after_err", reg_addr(SEL_EU, EU_BUFFER), '0, '0, 1'b0, '0);
    // events and interrupts, core 2 only listens to an idle line
    add_write("mask0_wr", reg_addr(SEL_EU, EU_MASK), 32'h0001, 1'b0, '0);
    add_write("mask1_wr", reg_addr(SEL_EU, EU_MASK + 4), 32'h1000, 1'b0, '0);
    add_write("mask2_wr", reg_addr(SEL_EU, EU_MASK + 8), 32'h0002, 1'b0, '0);
    add_write("mask3_wr", reg_addr(SEL_EU, EU_MASK + 12), 32'h1001, 1'b0, '0);
    add_read("ext_evt0_buf2", reg_addr(SEL_EU, EU_BUFFER + 8), 8'h01, 32'h0001, 1'b0, 4'b1001);
    add_write("sw_trig0", reg_addr(SEL_EU, EU_SW_TRIG), 32'h1, 1'b0, 4'b1011);
    add_read("buf1_rd", reg_addr(SEL_EU, EU_BUFFER + 4), '0, 32'h1001, 1'b0, 4'b1011);
    add_write("clear0", reg_addr(SEL_EU, EU_CLEAR), 32'hffff, 1'b0, 4'b1010);
    add_read("buf0_rd", reg_addr(SEL_EU, EU_BUFFER), '0, '0, 1'b0, 4'b1010);
    add_write("clear3_ext", reg_addr(SEL_EU, EU_CLEAR + 12), 32'h0001, 1'b0, 4'b1010);
    add_write("clear3_all", reg_addr(SEL_EU, EU_CLEAR + 12), 32'hffff, 1'b0, 4'b0010);
    add_read("buf3_rd", reg_addr(SEL_EU, EU_BUFFER + 12), '0, '0, 1'b0, 4'b0010);
    add_read("mask1_rd", reg_addr(SEL_EU, EU_MASK + 4), '0, 32'h1000, 1'b0, 4'b0010);
    add_write("clear1", reg_addr(SEL_EU, EU_CLEAR + 4), 32'hffff, 1'b0, '0);
    add_read("buf2_rd", reg_addr(SEL_EU, EU_BUFFER + 8), '0, 32'h1001, 1'b0, '0);
    // timer setup, core 1 listens to the timer bit only
    add_write("tmr_mask1", reg_addr(SEL_EU, EU_MASK + 4), 32'h1 << `CP_EU_TIMER_BIT, 1'b0, '0);
    add_write("tmr_cmp_wr", reg_addr(SEL_TIMER, TIMER_CMP), TMR_CMP, 1'b0, '0);
    add_read("tmr_cmp_rd", reg_addr(SEL_TIMER, TIMER_CMP), '0, TMR_CMP, 1'b0, '0);
    add_write("tmr_enable", reg_addr(SEL_TIMER, TIMER_CFG), 32'h1, 1'b0, '0);
  endtask

  // ******************************
  // APB driver
  // ******************************
  task automatic apb_xfer(input logic wr, input addr_t addr, input data_t wdata,
                          input ext_evt_t ext, output data_t rdata, output logic err);
    @(posedge clk);
    apb_req.psel    <= 1'b1;
    apb_req.penable <= 1'b0;
    apb_req.pwrite  <= wr;
    apb_req.paddr   <= addr;
    apb_req.pwdata  <= wdata;
    ext_evt         <= ext;
    @(posedge clk);
    apb_req.penable <= 1'b1;
    do begin
      @(negedge clk);
    end while (apb_rsp.pready !== 1'b1);
    rdata = apb_rsp.prdata;
    err   = apb_rsp.pslverr;
    @(posedge clk);
    apb_req <= '0;
    ext_evt <= '0;
  endtask

  // irq is sampled one cycle after the access edge
  task automatic run_entry(input string name, input entry_t e);
    data_t rdata;
    logic  err;
    apb_xfer(e.wr, e.addr, e.wdata, e.ext, rdata, err);
    @(posedge clk);
    @(negedge clk);
    if (!e.wr) check_data(name, e.rdata, rdata);
    check_bit({name, " pslverr"}, e.err, err);
    check_vec({name, " irq"}, e.irq, irq_req);
  endtask

  task automatic wait_timer_event();
    data_t rdata;
    logic  err;
    logic  seen;
    seen = 1'b0;
    for (int n = 0; n < 2 * TMR_CMP && !seen; n++) begin
      apb_xfer(1'b0, reg_addr(SEL_EU, EU_BUFFER + 4), '0, '0, rdata, err);
      seen = rdata[`CP_EU_TIMER_BIT];
    end
    if (!seen) fail_now("timer event never showed up in the event buffer of core 1");
    @(negedge clk);
    check_vec("tmr_irq1", 4'b0010, irq_req);
  endtask

  initial begin
    data_t cnt_a;
    data_t cnt_b;
    logic  err;
    clk     = 1'b0;
    arst_n  = 1'b0;
    apb_req = '0;
    ext_evt = '0;
    seed    = 32'hb2d6;
    errors  = 0;
    build_table();
    cycle_limit = 2 * CYC_PER_ENTRY * table_q.size() + 2 * TMR_CMP + 100;
    repeat (10) @(posedge clk);
    arst_n <= 1'b1;
    @(negedge clk);
    check_bit("rst_eoc_o", 1'b0, eoc);
    check_vec("rst_fetch_en_o", '0, fetch_en);
    check_vec("rst_irq_req_o", '0, irq_req);
    foreach (table_q[i]) begin
      run_entry(name_q[i], table_q[i]);
    end
    check_bit("eoc_o", 1'b1, eoc);
    check_vec("fetch_en_o", 4'b0101, fetch_en);
    for (int i = 0; i < `CP_NB_CORES; i++) begin
      check_data($sformatf("boot_addr_o[%0d]", i), boot_val[i], boot_addr[i]);
    end
    wait_timer_event();
    // stopped timer keeps its count
    apb_xfer(1'b1, reg_addr(SEL_TIMER, TIMER_CFG), '0, '0, cnt_a, err);
    apb_xfer(1'b0, reg_addr(SEL_TIMER, TIMER_CNT), '0, '0, cnt_a, err);
    apb_xfer(1'b0, reg_addr(SEL_TIMER, TIMER_CNT), '0, '0, cnt_b, err);
    check_data("tmr_cnt_stopped", cnt_a, cnt_b);
    if (errors == 0) begin
      $display("No errors");
      $finish;
    end else begin
      $display("Errors found");
      $fatal(1, "%0d checks failed", errors);
    end
  end

endmodule

`default_nettype wire

// ==== dv/cluster_periph_checker.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "cluster_periph_defs.svh"

module cluster_periph_checker
  import cluster_periph_pkg::*;
(
  input logic      clk_i,
  input logic      arst_n_i,
  input apb_req_t  apb_req_i,
  input apb_rsp_t  apb_rsp_i,
  input ext_evt_t  ext_evt_i,
  input core_vec_t irq_req_i
);

  logic                        eu_wr;
  logic [1:0]                  region;
  offs_t                       offs;
  evt_buf_t                    may_set;
  evt_buf_t [`CP_NB_CORES-1:0] mask_m;
  evt_buf_t [`CP_NB_CORES-1:0] buf_m;

  assign region = apb_req_i.paddr[`CP_REGION_LSB +: 2];
  assign offs   = apb_req_i.paddr[`CP_REGION_LSB-1:0];
  assign eu_wr  = apb_req_i.psel & apb_req_i.penable & apb_req_i.pwrite &
                  (apb_req_i.paddr[`CP_REGION_LSB +: 2] == SEL_EU);

  // word offsets that exist in each region's register map
  function automatic logic in_map(logic [1:0] region, offs_t o);
    logic aligned;
    aligned = (o[1:0] == 2'b00);
    case (region)
      2'd0: in_map = aligned && (o inside {CTRL_EOC, CTRL_FETCH_EN,
                     [CTRL_BOOT_ADDR:CTRL_BOOT_ADDR + 4 * (`CP_NB_CORES - 1)]});
      2'd1: in_map = aligned && (o inside {[TIMER_CFG:TIMER_RESET]});
      2'd2: in_map = aligned && (o inside {EU_SW_TRIG,
                     [EU_MASK:EU_MASK + 4 * (`CP_NB_CORES - 1)],
                     [EU_BUFFER:EU_BUFFER + 4 * (`CP_NB_CORES - 1)],
                     [EU_CLEAR:EU_CLEAR + 4 * (`CP_NB_CORES - 1)]});
      default: in_map = 1'b0;
    endcase
  endfunction

  // registers that reject writes
  function automatic logic read_only(logic [1:0] region, offs_t o);
    read_only = (region == 2'd2) && (o[1:0] == 2'b00) &&
                (o inside {[EU_BUFFER:EU_BUFFER + 4 * (`CP_NB_CORES - 1)]});
  endfunction

  // ******************************
  // port-level copy of masks and buffers
  // ******************************

  // the timer pulse is internal, so its buffer bit counts as possibly set
  always_comb begin
    may_set = '0;
    may_set[`CP_NB_EXT_EVT-1:0] = ext_evt_i;
    may_set[`CP_EU_TIMER_BIT]   = 1'b1;
    if (eu_wr && offs == EU_SW_TRIG) begin
      may_set[`CP_EU_SW_LSB +: `CP_EU_NB_SW] = apb_req_i.pwdata[`CP_EU_NB_SW-1:0];
    end
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      mask_m <= '0;
      buf_m  <= '0;
    end else begin
      for (int i = 0; i < `CP_NB_CORES; i++) begin
        if (eu_wr && offs == offs_t'(EU_MASK + 4 * i)) begin
          mask_m[i] <= apb_req_i.pwdata[`CP_EU_BUF_W-1:0];
        end
        if (eu_wr && offs == offs_t'(EU_CLEAR + 4 * i)) begin
          buf_m[i] <= (buf_m[i] & ~apb_req_i.pwdata[`CP_EU_BUF_W-1:0]) | may_set;
        end else begin
          buf_m[i] <= buf_m[i] | may_set;
        end
      end
    end
  end

  // ******************************
  // properties
  // ******************************
  a_no_wait: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    apb_req_i.psel && apb_req_i.penable |-> apb_rsp_i.pready)
    else $error("access phase without pready");

  a_slverr_cause: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    apb_rsp_i.pslverr |->
      !in_map(region, offs) || (apb_req_i.pwrite && read_only(region, offs)))
    else $error("pslverr on a mapped register that accepts this access");

  for (genvar c = 0; c < `CP_NB_CORES; c++) begin : g_irq
    a_irq_cause: assert property (@(posedge clk_i) disable iff (!arst_n_i)
      irq_req_i[c] |-> ($past(mask_m[c] & buf_m[c]) != '0))
      else $error("irq on core %0d without a pending unmasked event", c);
  end

endmodule

bind cluster_periph_top cluster_periph_checker cluster_periph_checker_i (
  .clk_i     ( clk_i     ),
  .arst_n_i  ( arst_n_i  ),
  .apb_req_i ( apb_req_i ),
  .apb_rsp_i ( apb_rsp_o ),
  .ext_evt_i ( ext_evt_i ),
  .irq_req_i ( irq_req_o )
);

`default_nettype wire

// ==== hdl/cluster_periph_top.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "cluster_periph_defs.svh"

module cluster_periph_top
  import cluster_periph_pkg::*;
(
  input  logic       clk_i,
  input  logic       arst_n_i,

  input  apb_req_t   apb_req_i,
  output apb_rsp_t   apb_rsp_o,

  input  ext_evt_t   ext_evt_i,

  output logic       eoc_o,
  output core_vec_t  fetch_en_o,
  output boot_addr_t boot_addr_o,
  output core_vec_t  irq_req_o
);

  apb_req_t ctrl_req, timer_req, eu_req;
  apb_rsp_t ctrl_rsp, timer_rsp, eu_rsp;
  logic     timer_evt;

  // ****************************
  // APB region decode
  // ****************************
  periph_apb_demux periph_apb_demux_i (
    .apb_req_i   ( apb_req_i ),
    .apb_rsp_o   ( apb_rsp_o ),
    .ctrl_req_o  ( ctrl_req  ),
    .timer_req_o ( timer_req ),
    .eu_req_o    ( eu_req    ),
    .ctrl_rsp_i  ( ctrl_rsp  ),
    .timer_rsp_i ( timer_rsp ),
    .eu_rsp_i    ( eu_rsp    )
  );

  // ****************************
  // peripherals
  // ****************************
  cluster_ctrl_unit cluster_ctrl_unit_i (
    .clk_i       ( clk_i       ),
    .arst_n_i    ( arst_n_i    ),
    .apb_req_i   ( ctrl_req    ),
    .apb_rsp_o   ( ctrl_rsp    ),
    .eoc_o       ( eoc_o       ),
    .fetch_en_o  ( fetch_en_o  ),
    .boot_addr_o ( boot_addr_o )
  );

  cluster_timer cluster_timer_i (
    .clk_i       ( clk_i     ),
    .arst_n_i    ( arst_n_i  ),
    .apb_req_i   ( timer_req ),
    .apb_rsp_o   ( timer_rsp ),
    .timer_evt_o ( timer_evt )
  );

  event_unit event_unit_i (
    .clk_i       ( clk_i     ),
    .arst_n_i    ( arst_n_i  ),
    .apb_req_i   ( eu_req    ),
    .apb_rsp_o   ( eu_rsp    ),
    .timer_evt_i ( timer_evt ),
    .ext_evt_i   ( ext_evt_i ),
    .irq_req_o   ( irq_req_o )
  );

endmodule

`default_nettype wire

// ==== hdl/event_unit.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "cluster_periph_defs.svh"

module event_unit
  import cluster_periph_pkg::*;
(
  input  logic      clk_i,
  input  logic      arst_n_i,

  input  apb_req_t  apb_req_i,
  output apb_rsp_t  apb_rsp_o,

  input  logic      timer_evt_i,
  input  ext_evt_t  ext_evt_i,

  output core_vec_t irq_req_o
);

  logic     access;
  logic     wr_en;
  offs_t    offs;
  logic     hit;
  logic     ro_err;
  data_t    rdata;
  evt_buf_t set_vec;

  core_vec_t mask_hit;
  core_vec_t buf_hit;
  core_vec_t clr_hit;

  evt_buf_t [`CP_NB_CORES-1:0] mask_q;
  evt_buf_t [`CP_NB_CORES-1:0] buf_q;
  evt_buf_t [`CP_NB_CORES-1:0] clr_vec;
  core_vec_t                   irq_q;

  assign access = apb_req_i.psel & apb_req_i.penable;
  assign wr_en  = access & apb_req_i.pwrite;
  assign offs   = apb_req_i.paddr[`CP_REGION_LSB-1:0];

  // ****************************
  // register decode
  // ****************************
  always_comb begin
    for (int i = 0; i < `CP_NB_CORES; i++) begin
      mask_hit[i] = (offs == offs_t'(EU_MASK + 4 * i));
      buf_hit[i]  = (offs == offs_t'(EU_BUFFER + 4 * i));
      clr_hit[i]  = (offs == offs_t'(EU_CLEAR + 4 * i));
    end
  end

  always_comb begin
    rdata  = '0;
    hit    = (offs == EU_SW_TRIG) | (|mask_hit) | (|buf_hit) | (|clr_hit);
    ro_err = apb_req_i.pwrite & (|buf_hit);
    for (int i = 0; i < `CP_NB_CORES; i++) begin
      if (mask_hit[i]) rdata = data_t'(mask_q[i]);
      if (buf_hit[i]) rdata = data_t'(buf_q[i]);
    end
  end

  assign apb_rsp_o.pready  = 1'b1;
  assign apb_rsp_o.prdata  = rdata;
  assign apb_rsp_o.pslverr = access & (~hit | ro_err);

  // ****************************
  // event sources
  // ****************************

  // shared by all cores: external lines, timer and sw triggers
  always_comb begin
    set_vec = '0;
    set_vec[`CP_NB_EXT_EVT-1:0] = ext_evt_i;
    set_vec[`CP_EU_TIMER_BIT]   = timer_evt_i;
    if (wr_en && offs == EU_SW_TRIG) begin
      set_vec[`CP_EU_SW_LSB +: `CP_EU_NB_SW] = apb_req_i.pwdata[`CP_EU_NB_SW-1:0];
    end
  end

  always_comb begin
    for (int i = 0; i < `CP_NB_CORES; i++) begin
      clr_vec[i] = (wr_en && clr_hit[i]) ? apb_req_i.pwdata[`CP_EU_BUF_W-1:0] : '0;
    end
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      mask_q <= '0;
      buf_q  <= '0;
      irq_q  <= '0;
    end else begin
      for (int i = 0; i < `CP_NB_CORES; i++) begin
        if (wr_en && mask_hit[i]) mask_q[i] <= apb_req_i.pwdata[`CP_EU_BUF_W-1:0];
        // set wins over a clear on the same bit
        buf_q[i] <= (buf_q[i] & ~clr_vec[i]) | set_vec;
        irq_q[i] <= |(buf_q[i] & mask_q[i]);
      end
    end
  end

  assign irq_req_o = irq_q;

endmodule

`default_nettype wire

// ==== hdl/cluster_timer.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "cluster_periph_defs.svh"

module cluster_timer
  import cluster_periph_pkg::*;
(
  input  logic     clk_i,
  input  logic     arst_n_i,

  input  apb_req_t apb_req_i,
  output apb_rsp_t apb_rsp_o,

  output logic     timer_evt_o
);

  logic  access;
  logic  wr_en;
  offs_t offs;
  logic  hit;
  data_t rdata;
  logic  cnt_match;

  logic  en_q;
  data_t cnt_q;
  data_t cmp_q;
  logic  evt_q;

  assign access    = apb_req_i.psel & apb_req_i.penable;
  assign wr_en     = access & apb_req_i.pwrite;
  assign offs      = apb_req_i.paddr[`CP_REGION_LSB-1:0];
  assign cnt_match = (cnt_q == cmp_q);

  always_comb begin
    rdata = '0;
    hit   = 1'b1;
    case (offs)
      TIMER_CFG:   rdata = data_t'(en_q);
      TIMER_CNT:   rdata = cnt_q;
      TIMER_CMP:   rdata = cmp_q;
      // write-only strobe, reads as zero
      TIMER_RESET: rdata = '0;
      default:     hit   = 1'b0;
    endcase
  end

  assign apb_rsp_o.pready  = 1'b1;
  assign apb_rsp_o.prdata  = rdata;
  assign apb_rsp_o.pslverr = access & ~hit;

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      en_q  <= 1'b0;
      cnt_q <= '0;
      cmp_q <= '1;
      evt_q <= 1'b0;
    end else begin
      // event comes out one cycle after the match, as the counter wraps
      evt_q <= en_q & cnt_match;

      if (wr_en && offs == TIMER_CFG) en_q <= apb_req_i.pwdata[0];
      if (wr_en && offs == TIMER_CMP) cmp_q <= apb_req_i.pwdata;

      // bus writes take priority over counting
      if (wr_en && offs == TIMER_CNT) begin
        cnt_q <= apb_req_i.pwdata;
      end else if (wr_en && offs == TIMER_RESET) begin
        cnt_q <= '0;
      end else if (en_q) begin
        cnt_q <= cnt_match ? '0 : cnt_q + 1'b1;
      end
    end
  end

  assign timer_evt_o = evt_q;

endmodule

`default_nettype wire

// ==== hdl/cluster_ctrl_unit.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "cluster_periph_defs.svh"

module cluster_ctrl_unit
  import cluster_periph_pkg::*;
(
  input  logic       clk_i,
  input  logic       arst_n_i,

  input  apb_req_t   apb_req_i,
  output apb_rsp_t   apb_rsp_o,

  output logic       eoc_o,
  output core_vec_t  fetch_en_o,
  output boot_addr_t boot_addr_o
);

  logic       access;
  logic       wr_en;
  offs_t      offs;
  logic       hit;
  data_t      rdata;
  core_vec_t  boot_hit;

  logic       eoc_q;
  core_vec_t  fetch_en_q;
  boot_addr_t boot_addr_q;

  assign access = apb_req_i.psel & apb_req_i.penable;
  assign wr_en  = access & apb_req_i.pwrite;
  assign offs   = apb_req_i.paddr[`CP_REGION_LSB-1:0];

  // one boot address word per core
  always_comb begin
    for (int i = 0; i < `CP_NB_CORES; i++) begin
      boot_hit[i] = (offs == offs_t'(CTRL_BOOT_ADDR + 4 * i));
    end
  end

  // readback
  always_comb begin
    rdata = '0;
    hit   = 1'b1;
    case (offs)
      CTRL_EOC:      rdata = data_t'(eoc_q);
      CTRL_FETCH_EN: rdata = data_t'(fetch_en_q);
      default: begin
        hit = |boot_hit;
        for (int i = 0; i < `CP_NB_CORES; i++) begin
          if (boot_hit[i]) rdata = boot_addr_q[i];
        end
      end
    endcase
  end

  assign apb_rsp_o.pready  = 1'b1;
  assign apb_rsp_o.prdata  = rdata;
  assign apb_rsp_o.pslverr = access & ~hit;

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      eoc_q       <= 1'b0;
      fetch_en_q  <= '0;
      boot_addr_q <= {`CP_NB_CORES{data_t'(`CP_BOOT_ADDR_RST)}};
    end else if (wr_en) begin
      if (offs == CTRL_EOC) eoc_q <= apb_req_i.pwdata[0];
      if (offs == CTRL_FETCH_EN) fetch_en_q <= apb_req_i.pwdata[`CP_NB_CORES-1:0];
      for (int i = 0; i < `CP_NB_CORES; i++) begin
        if (boot_hit[i]) boot_addr_q[i] <= apb_req_i.pwdata;
      end
    end
  end

  assign eoc_o       = eoc_q;
  assign fetch_en_o  = fetch_en_q;
  assign boot_addr_o = boot_addr_q;

endmodule

`default_nettype wire

// ==== hdl/periph_apb_demux.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "cluster_periph_defs.svh"

module periph_apb_demux
  import cluster_periph_pkg::*;
(
  input  apb_req_t apb_req_i,
  output apb_rsp_t apb_rsp_o,

  output apb_req_t ctrl_req_o,
  output apb_req_t timer_req_o,
  output apb_req_t eu_req_o,

  input  apb_rsp_t ctrl_rsp_i,
  input  apb_rsp_t timer_rsp_i,
  input  apb_rsp_t eu_rsp_i
);

  periph_sel_e sel;
  apb_req_t    sub_req;

  assign sel = periph_sel_e'(apb_req_i.paddr[`CP_REGION_LSB +: 2]);

  // peripherals only see the offset inside their region
  always_comb begin
    sub_req = apb_req_i;
    sub_req.paddr[`CP_ADDR_W-1:`CP_REGION_LSB] = '0;

    ctrl_req_o  = sub_req;
    timer_req_o = sub_req;
    eu_req_o    = sub_req;

    ctrl_req_o.psel  = apb_req_i.psel && (sel == SEL_CTRL);
    timer_req_o.psel = apb_req_i.psel && (sel == SEL_TIMER);
    eu_req_o.psel    = apb_req_i.psel && (sel == SEL_EU);
  end

  // response mux
  always_comb begin
    case (sel)
      SEL_CTRL:  apb_rsp_o = ctrl_rsp_i;
      SEL_TIMER: apb_rsp_o = timer_rsp_i;
      SEL_EU:    apb_rsp_o = eu_rsp_i;
      default: begin
        // unmapped region, completed here with an error
        apb_rsp_o.pready  = 1'b1;
        apb_rsp_o.prdata  = '0;
        apb_rsp_o.pslverr = apb_req_i.psel & apb_req_i.penable;
      end
    endcase
  end

endmodule

`default_nettype wire

// ==== hdl/cluster_periph_pkg.sv ====
`default_nettype none

`include "cluster_periph_defs.svh"

package cluster_periph_pkg;

  typedef logic [`CP_DATA_W-1:0]     data_t;
  typedef logic [`CP_ADDR_W-1:0]     addr_t;
  typedef logic [`CP_REGION_LSB-1:0] offs_t;
  typedef logic [`CP_NB_CORES-1:0]   core_vec_t;
  typedef logic [`CP_EU_BUF_W-1:0]   evt_buf_t;
  typedef logic [`CP_NB_EXT_EVT-1:0] ext_evt_t;
  typedef data_t [`CP_NB_CORES-1:0]  boot_addr_t;

  typedef struct packed {
    logic  psel;
    logic  penable;
    logic  pwrite;
    addr_t paddr;
    data_t pwdata;
  } apb_req_t;

  typedef struct packed {
    logic  pready;
    data_t prdata;
    logic  pslverr;
  } apb_rsp_t;

  typedef enum logic [1:0] {SEL_CTRL, SEL_TIMER, SEL_EU, SEL_NONE} periph_sel_e;

  // per-core registers sit at base + 4 * core
  typedef enum offs_t {CTRL_EOC = 'h00, CTRL_FETCH_EN = 'h08, CTRL_BOOT_ADDR = 'h40} ctrl_reg_e;

  typedef enum offs_t {TIMER_CFG = 'h00, TIMER_CNT = 'h04, TIMER_CMP = 'h08,
                       TIMER_RESET = 'h0C} timer_reg_e;

  typedef enum offs_t {EU_MASK = 'h00, EU_BUFFER = 'h20, EU_CLEAR = 'h40,
                       EU_SW_TRIG = 'h60} eu_reg_e;

endpackage

`default_nettype wire

// ==== hdl/cluster_periph_defs.svh ====
`ifndef CLUSTER_PERIPH_DEFS_SVH
`define CLUSTER_PERIPH_DEFS_SVH

// cluster size, shared by every register map
`define CP_NB_CORES 4

// bus widths
`define CP_DATA_W 32
`define CP_ADDR_W 12

// external event lines into the event unit
`define CP_NB_EXT_EVT 8

// 2-bit region field: 0 control, 1 timer, 2 event unit, 3 unmapped
`define CP_REGION_LSB 10

`define CP_BOOT_ADDR_RST 32'h1C000000

// event buffer layout
`define CP_EU_BUF_W 16
`define CP_EU_TIMER_BIT 8
`define CP_EU_SW_LSB 12
`define CP_EU_NB_SW 4

`endif
